// ==== src.f ====
+incdir+include
logic/icache_pkg.sv
logic/icache_lookup_if.sv
logic/icache_addr_decode.sv
logic/icache_ctrl.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/icache_top.sv
dv/icache_assertions.sv
dv/tb_clock_gen.sv
dv/icache_tb.sv

// ==== Makefile ====
TOP := icache_tb

.PHONY: all lint clean

# build, run, and pass only when the pass line shows up in the output
all:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir

// ==== dv/icache_tb.sv ====
// drives the cache through misses, hits, set conflicts and flushes against a memory model
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_tb;

  localparam int          ADDR_W     = `ICACHE_ADDR_WIDTH;
  localparam int          WORD_W     = `ICACHE_FETCH_WIDTH;
  localparam int          LINE_W     = `ICACHE_LINE_BYTES * 8;
  localparam int          WORDS      = LINE_W / WORD_W;
  localparam logic [31:0] FILL_XOR   = 32'hA5A5_0000;
  localparam logic [31:0] SEED       = 32'h934f3b86;
  localparam int          CONFLICTS  = 12;
  localparam int          RANDOM_CNT = 40;
  // about 65 fetches of at most 12 cycles, reset and two flush sweeps
  localparam int          EXPECTED_CYCLES = 800;
  localparam int          TIMEOUT_CYCLES  = 4 * EXPECTED_CYCLES;

  logic              clk;
  logic              rst_n;
  logic              flush_i;
  logic              fetch_req_i;
  logic [ADDR_W-1:0] fetch_addr_i;
  logic              fetch_ready_o;
  logic              fetch_valid_o;
  logic [WORD_W-1:0] fetch_data_o;
  logic              miss_o;
  logic              fill_req_o;
  logic [ADDR_W-1:0] fill_addr_o;
  logic              fill_ack_i;
  logic              fill_vld_i;
  logic [LINE_W-1:0] fill_data_i;

  tb_clock_gen tb_clock_gen_inst (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  icache_top icache_top_inst (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .flush_i      (flush_i),
    .fetch_req_i  (fetch_req_i),
    .fetch_addr_i (fetch_addr_i),
    .fetch_ready_o(fetch_ready_o),
    .fetch_valid_o(fetch_valid_o),
    .fetch_data_o (fetch_data_o),
    .miss_o       (miss_o),
    .fill_req_o   (fill_req_o),
    .fill_addr_o  (fill_addr_o),
    .fill_ack_i   (fill_ack_i),
    .fill_vld_i   (fill_vld_i),
    .fill_data_i  (fill_data_i)
  );

  bind icache_top icache_assertions icache_assertions_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .fetch_req_i  (fetch_req_i),
    .fetch_addr_i (fetch_addr_i),
    .fetch_ready_i(fetch_ready_o),
    .fetch_valid_i(fetch_valid_o),
    .fetch_data_i (fetch_data_o),
    .miss_i       (miss_o),
    .fill_req_i   (fill_req_o),
    .fill_addr_i  (fill_addr_o),
    .fill_ack_i   (fill_ack_i),
    .fill_vld_i   (fill_vld_i)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // memory contents, each word holds its own byte address xor a constant
  function automatic logic [LINE_W-1:0] make_line(input logic [ADDR_W-1:0] line_addr);
    logic [LINE_W-1:0] line;
    logic [ADDR_W-1:0] word_addr;
    line = '0;
    for (int w = 0; w < WORDS; w++) begin
      word_addr = line_addr + ADDR_W'(w * (WORD_W / 8));
      line[w*WORD_W +: WORD_W] = word_addr ^ FILL_XOR;
    end
    return line;
  endfunction

  function automatic int unsigned total_errors();
    return icache_top_inst.icache_assertions_inst.flush_err +
           icache_top_inst.icache_assertions_inst.fill_err +
           icache_top_inst.icache_assertions_inst.data_err +
           icache_top_inst.icache_assertions_inst.hit_err;
  endfunction

  task automatic report_counts(input bit timed_out);
    $display("error counts: flush %0d, fill %0d, data %0d, hit %0d, timeout %0d",
             icache_top_inst.icache_assertions_inst.flush_err,
             icache_top_inst.icache_assertions_inst.fill_err,
             icache_top_inst.icache_assertions_inst.data_err,
             icache_top_inst.icache_assertions_inst.hit_err,
             timed_out);
  endtask

  // one fetch, returns once the cache is ready for the next one
  task automatic fetch_word(input logic [ADDR_W-1:0] addr);
    @(negedge clk);
    fetch_req_i  = 1'b1;
    fetch_addr_i = addr;
    // ready is stable mid cycle, the request is taken at the next rising edge
    while (!fetch_ready_o) @(negedge clk);
    @(negedge clk);
    fetch_req_i = 1'b0;
    // high again in the hit cycle, or after the fill on a miss
    while (!fetch_ready_o) @(negedge clk);
  endtask

  task automatic flush_cache();
    @(negedge clk);
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////

  // ack and line return each after 0 to 3 cycles
  initial begin : memory_model
    logic [31:0]       rng;
    logic [ADDR_W-1:0] line_addr;
    int                ack_delay;
    int                vld_delay;
    rng         = SEED;
    fill_ack_i  = 1'b0;
    fill_vld_i  = 1'b0;
    fill_data_i = '0;
    forever begin
      @(negedge clk);
      if (rst_n && fill_req_o) begin
        line_addr = fill_addr_o;
        rng       = xorshift(rng);
        ack_delay = int'(rng[1:0]);
        vld_delay = int'(rng[9:8]);
        repeat (ack_delay) @(negedge clk);
        fill_ack_i = 1'b1;
        @(negedge clk);
        fill_ack_i = 1'b0;
        repeat (vld_delay) @(negedge clk);
        fill_vld_i  = 1'b1;
        fill_data_i = make_line(line_addr);
        @(negedge clk);
        fill_vld_i  = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0]       rng;
    logic [ADDR_W-1:0] addr;
    rng          = xorshift(SEED);
    flush_i      = 1'b0;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    @(posedge rst_n);
    // first access misses, the repeats hit the same line
    fetch_word(32'h0000_1004);
    fetch_word(32'h0000_1008);
    fetch_word(32'h0000_1004);
    fetch_word(32'h0000_20FC);
    fetch_word(32'h0000_20F0);
    fetch_word(32'h0000_1000);
    // three tags share set 3, two ways keep evicting
    for (int i = 0; i < CONFLICTS; i++) begin
      rng  = xorshift(rng);
      addr = 32'h0000_1030 + ((rng % 32'd3) << 8) + {28'd0, rng[9:8], 2'b00};
      fetch_word(addr);
    end
    // hit line goes away with the flush
    fetch_word(32'h0000_1004);
    flush_cache();
    fetch_word(32'h0000_1004);
    fetch_word(32'h0000_100C);
    // random words in a 4 KiB window, many set conflicts
    for (int i = 0; i < RANDOM_CNT; i++) begin
      rng  = xorshift(rng);
      addr = {20'h0_0000, rng[11:2], 2'b00};
      fetch_word(addr);
    end
    repeat (4) @(posedge clk);
    report_counts(1'b0);
    if (total_errors() == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
    report_counts(1'b1);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== dv/tb_clock_gen.sv ====
// testbench clock and active low reset source, instantiated once by the testbench top
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int RESET_CYCLES = 10;

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== dv/icache_assertions.sv ====
// concurrent checks on the cache ports, bound into the cache top level by the testbench
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_assertions (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           flush_i,
  input logic                           fetch_req_i,
  input logic [`ICACHE_ADDR_WIDTH-1:0]  fetch_addr_i,
  input logic                           fetch_ready_i,
  input logic                           fetch_valid_i,
  input logic [`ICACHE_FETCH_WIDTH-1:0] fetch_data_i,
  input logic                           miss_i,
  input logic                           fill_req_i,
  input logic [`ICACHE_ADDR_WIDTH-1:0]  fill_addr_i,
  input logic                           fill_ack_i,
  input logic                           fill_vld_i
);

  localparam int          ADDR_W      = `ICACHE_ADDR_WIDTH;
  localparam int          LINE_OFF_W  = $clog2(`ICACHE_LINE_BYTES);
  localparam int          WORD_BYTE_W = $clog2(`ICACHE_FETCH_WIDTH / 8);
  localparam int unsigned SETS        = `ICACHE_SETS;
  localparam logic [31:0] FILL_XOR    = 32'hA5A5_0000;

  logic              accept;
  // address of the request in flight
  logic [ADDR_W-1:0] req_addr_q;
  // most recent fill, still resident until the next fill or flush
  logic [ADDR_W-1:0] last_line_q;
  logic              last_vld_q;
  // a flush was asked for and no fetch has been taken since
  logic              flush_pend_q;
  // cycles since reset release, saturating
  int unsigned       cyc_q;

  // failure counts, read by the testbench for its closing line
  int unsigned flush_err = 0;
  int unsigned fill_err  = 0;
  int unsigned data_err  = 0;
  int unsigned hit_err   = 0;

  // memory word rule, byte address of the word xor a constant
  function automatic logic [31:0] rule_word(input logic [ADDR_W-1:0] addr);
    return {addr[ADDR_W-1:WORD_BYTE_W], {WORD_BYTE_W{1'b0}}} ^ FILL_XOR;
  endfunction

  function automatic logic [ADDR_W-1:0] line_of(input logic [ADDR_W-1:0] addr);
    return {addr[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
  endfunction

  assign accept = fetch_req_i && fetch_ready_i;

  //////////////////////////////////////////////////
  // reference state
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_addr_q   <= '0;
      last_line_q  <= '0;
      last_vld_q   <= 1'b0;
      flush_pend_q <= 1'b0;
      cyc_q        <= 0;
    end else begin
      if (cyc_q < SETS) begin
        cyc_q <= cyc_q + 1;
      end
      if (accept) begin
        req_addr_q <= fetch_addr_i;
      end
      // fetches taken after the flush request see an empty cache
      if (flush_i) begin
        flush_pend_q <= 1'b1;
        last_vld_q   <= 1'b0;
      end else if (accept) begin
        flush_pend_q <= 1'b0;
      end
      // fills of requests from before a pending flush are not tracked
      if (fill_vld_i && fetch_valid_i && !flush_pend_q && !flush_i) begin
        last_line_q <= line_of(req_addr_q);
        last_vld_q  <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // reset flush and flush requests
  //////////////////////////////////////////////////

  a_flush_quiet : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cyc_q < SETS) |-> !fetch_ready_i && !fetch_valid_i && !fill_req_i && !miss_i)
    else begin
      flush_err++;
      $error("fetch or refill activity during the reset flush sweep");
    end

  a_flush_miss : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept && flush_pend_q |=> fill_req_i && !fetch_valid_i)
    else begin
      flush_err++;
      $error("first fetch after a flush did not miss");
    end

  //////////////////////////////////////////////////
  // refill handshake
  //////////////////////////////////////////////////

  a_fill_addr : assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_req_i |-> fill_addr_i == line_of(req_addr_q))
    else begin
      fill_err++;
      $error("Fail fill_addr_o exp %h got %h",
             line_of($sampled(req_addr_q)), $sampled(fill_addr_i));
    end

  a_fill_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_req_i && !fill_ack_i |=> fill_req_i && $stable(fill_addr_i))
    else begin
      fill_err++;
      $error("refill request dropped or changed before its acknowledge");
    end

  // exactly one miss pulse, in the acknowledge cycle
  a_miss_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    miss_i == (fill_req_i && fill_ack_i))
    else begin
      fill_err++;
      $error("miss pulse not aligned with the refill acknowledge");
    end

  //////////////////////////////////////////////////
  // returned data and hit timing
  //////////////////////////////////////////////////

  a_data : assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_i |-> fetch_data_i == rule_word(req_addr_q))
    else begin
      data_err++;
      $error("Fail fetch_data_o exp %h got %h",
             rule_word($sampled(req_addr_q)), $sampled(fetch_data_i));
    end

  // every accepted fetch either hits or asks for a refill next cycle
  a_answer : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |=> fetch_valid_i || fill_req_i)
    else begin
      hit_err++;
      $error("accepted fetch got neither data nor a refill request");
    end

  a_hit : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept && !flush_i && last_vld_q && line_of(fetch_addr_i) == last_line_q
    |=> fetch_valid_i && !fill_req_i)
    else begin
      hit_err++;
      $error("fetch to the last filled line did not hit one cycle after accept");
    end

endmodule

// ==== logic/icache_top.sv ====
// instruction cache top level with plain fetch and refill ports
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  flush_i,
  // fetch side
  input  logic  fetch_req_i,
  input  addr_t fetch_addr_i,
  output logic  fetch_ready_o,
  output logic  fetch_valid_o,
  output word_t fetch_data_o,
  // performance counter
  output logic  miss_o,
  // refill side
  output logic  fill_req_o,
  output addr_t fill_addr_o,
  input  logic  fill_ack_i,
  input  logic  fill_vld_i,
  input  line_t fill_data_i
);

  // tag array results
  logic hit;
  way_t hit_way;
  way_t fill_way;
  logic flush_done;
  // ctrl strobes to the arrays
  logic flush_en;
  logic fill_we;
  logic latch_repl;
  logic sel_fill;

  icache_lookup_if lookup_if ();

  icache_addr_decode icache_addr_decode_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fetch_req_i  (fetch_req_i),
    .fetch_addr_i (fetch_addr_i),
    .fetch_ready_i(fetch_ready_o),
    .lookup       (lookup_if)
  );

  icache_ctrl icache_ctrl_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .lookup       (lookup_if),
    .hit_i        (hit),
    .flush_done_i (flush_done),
    .fill_ack_i   (fill_ack_i),
    .fill_vld_i   (fill_vld_i),
    .fetch_ready_o(fetch_ready_o),
    .fetch_valid_o(fetch_valid_o),
    .miss_o       (miss_o),
    .fill_req_o   (fill_req_o),
    .flush_en_o   (flush_en),
    .fill_we_o    (fill_we),
    .latch_repl_o (latch_repl),
    .sel_fill_o   (sel_fill),
    .fill_addr_o  (fill_addr_o)
  );

  icache_tag_array icache_tag_array_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lookup      (lookup_if),
    .flush_en_i  (flush_en),
    .fill_we_i   (fill_we),
    .latch_repl_i(latch_repl),
    .hit_o       (hit),
    .hit_way_o   (hit_way),
    .fill_way_o  (fill_way),
    .flush_done_o(flush_done)
  );

  icache_data_array icache_data_array_inst (
    .clk_i       (clk_i),
    .lookup      (lookup_if),
    .hit_way_i   (hit_way),
    .fill_way_i  (fill_way),
    .fill_we_i   (fill_we),
    .sel_fill_i  (sel_fill),
    .fill_data_i (fill_data_i),
    .fetch_data_o(fetch_data_o)
  );

endmodule

// ==== logic/icache_data_array.sv ====
// line store with fetch word selection from the hit way or the incoming fill line
`timescale 1ns/1ps

module icache_data_array import icache_pkg::*; (
  input  logic  clk_i,
  icache_lookup_if.lookup lookup,
  input  way_t  hit_way_i,
  input  way_t  fill_way_i,
  input  logic  fill_we_i,
  input  logic  sel_fill_i,
  input  line_t fill_data_i,
  output word_t fetch_data_o
);

  line_t line_mem  [SETS][WAYS];
  // both ways read together, way picked after the compare
  line_t line_rd_q [WAYS];
  line_t sel_line;

  //////////////////////////////////////////////////
  // storage and read port
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    // rd_index holds the miss index during the fill
    if (fill_we_i) begin
      line_mem[lookup.rd_index][fill_way_i] <= fill_data_i;
    end
    if (lookup.accept) begin
      for (int w = 0; w < WAYS; w++) begin
        line_rd_q[w] <= line_mem[lookup.rd_index][w];
      end
    end
  end

  // fill line bypasses the store on a miss
  assign sel_line = sel_fill_i ? fill_data_i : line_rd_q[hit_way_i];

  // word of the request in flight
  assign fetch_data_o = sel_line[lookup.offset];

endmodule

// ==== logic/icache_tag_array.sv ====
// tag and valid store with hit compare, flush sweep and replacement way choice
`timescale 1ns/1ps

module icache_tag_array import icache_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  icache_lookup_if.lookup lookup,
  input  logic flush_en_i,
  input  logic fill_we_i,
  input  logic latch_repl_i,
  output logic hit_o,
  output way_t hit_way_o,
  output way_t fill_way_o,
  output logic flush_done_o
);

  // storage, valid bits cleared by the flush sweep
  way_vec_t   valid_mem [SETS];
  tag_t       tag_mem   [SETS][WAYS];
  // synchronous read registers
  way_vec_t   valid_rd_q;
  tag_t       tag_rd_q  [WAYS];
  way_vec_t   hit_vec;
  way_t       inv_way;
  way_t       rnd_way;
  way_t       repl_way_q;
  logic       all_valid;
  logic       repl_was_valid_q;
  index_t     flush_cnt_q;
  logic [7:0] lfsr_q;
  logic       lfsr_fb;

  //////////////////////////////////////////////////
  // storage and read port
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (flush_en_i) begin
      valid_mem[flush_cnt_q] <= '0;
    end else if (fill_we_i) begin
      valid_mem[lookup.rd_index][fill_way_o] <= 1'b1;
      tag_mem[lookup.rd_index][fill_way_o]   <= lookup.tag;
    end
    // read only when a fetch is taken
    if (lookup.accept) begin
      valid_rd_q <= valid_mem[lookup.rd_index];
      for (int w = 0; w < WAYS; w++) begin
        tag_rd_q[w] <= tag_mem[lookup.rd_index][w];
      end
    end
  end

  //////////////////////////////////////////////////
  // hit compare and first invalid way
  //////////////////////////////////////////////////

  // walk downwards so the lowest way wins
  always_comb begin
    hit_way_o = '0;
    inv_way   = '0;
    for (int w = WAYS - 1; w >= 0; w--) begin
      hit_vec[w] = valid_rd_q[w] && (tag_rd_q[w] == lookup.tag);
      if (hit_vec[w]) begin
        hit_way_o = way_t'(w);
      end
      if (!valid_rd_q[w]) begin
        inv_way = way_t'(w);
      end
    end
  end

  assign hit_o     = |hit_vec;
  assign all_valid = &valid_rd_q;

  // random way once the set is full
  assign rnd_way    = lfsr_q[WAY_W-1:0];
  // taps for x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb    = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
  assign fill_way_o = repl_way_q;

  // last set of the sweep
  assign flush_done_o = flush_en_i && (flush_cnt_q == index_t'(SETS - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_cnt_q      <= '0;
      lfsr_q           <= LFSR_SEED;
      repl_way_q       <= '0;
      repl_was_valid_q <= 1'b0;
    end else begin
      // wraps back to zero at the end of the sweep
      if (flush_en_i) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
      // way chosen at the miss
      if (latch_repl_i) begin
        repl_way_q       <= all_valid ? rnd_way : inv_way;
        repl_was_valid_q <= all_valid;
      end
      // step only when a valid line gets evicted
      if (fill_we_i && repl_was_valid_q) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_fb};
      end
    end
  end

endmodule

// ==== logic/icache_ctrl.sv ====
// cache controller FSM covering flush, lookup, refill request and fill return
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  flush_i,
  icache_lookup_if.lookup lookup,
  input  logic  hit_i,
  input  logic  flush_done_i,
  input  logic  fill_ack_i,
  input  logic  fill_vld_i,
  output logic  fetch_ready_o,
  output logic  fetch_valid_o,
  output logic  miss_o,
  output logic  fill_req_o,
  output logic  flush_en_o,
  output logic  fill_we_o,
  output logic  latch_repl_o,
  output logic  sel_fill_o,
  output addr_t fill_addr_o
);

  ctrl_state_e state_d, state_q;
  // pending flush request
  logic flush_d, flush_q;

  // line aligned refill address of the request in flight
  assign fill_addr_o = {lookup.tag, lookup.rd_index, {LINE_OFF_W{1'b0}}};

  // fetch word comes from the fill line while waiting for it
  assign sel_fill_o = (state_q == MISS);

  //////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    // remember flush until the next idle entry
    flush_d       = flush_q | flush_i;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    miss_o        = 1'b0;
    fill_req_o    = 1'b0;
    flush_en_o    = 1'b0;
    fill_we_o     = 1'b0;
    latch_repl_o  = 1'b0;

    unique case (state_q)
      // clear one set per cycle
      FLUSH: begin
        flush_en_o = 1'b1;
        if (flush_done_i) begin
          state_d = IDLE;
          flush_d = 1'b0;
        end
      end
      // wait for a fetch
      IDLE: begin
        if (flush_q) begin
          state_d = FLUSH;
        end else begin
          fetch_ready_o = 1'b1;
          if (lookup.accept) begin
            state_d = READ;
          end
        end
      end
      // tag compare on the registered read
      READ: begin
        if (hit_i) begin
          fetch_valid_o = 1'b1;
          state_d       = IDLE;
          // back to back accept unless a flush waits
          if (!flush_q) begin
            fetch_ready_o = 1'b1;
            if (lookup.accept) begin
              state_d = READ;
            end
          end
        end else begin
          // hold the refill request until acknowledged
          fill_req_o   = 1'b1;
          latch_repl_o = 1'b1;
          if (fill_ack_i) begin
            miss_o  = 1'b1;
            state_d = MISS;
          end
        end
      end
      // fill line is taken whenever it shows up
      MISS: begin
        if (fill_vld_i) begin
          fill_we_o     = 1'b1;
          fetch_valid_o = 1'b1;
          state_d       = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  // cache contents are unknown out of reset, so start with a flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FLUSH;
      flush_q <= 1'b0;
    end else begin
      state_q <= state_d;
      flush_q <= flush_d;
    end
  end

endmodule

// ==== logic/icache_addr_decode.sv ====
// takes a fetch and splits its address into tag, index and word offset for the lookup
`timescale 1ns/1ps

module icache_addr_decode import icache_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  fetch_req_i,
  input  addr_t fetch_addr_i,
  input  logic  fetch_ready_i,
  icache_lookup_if.decode lookup
);

  logic    accept;
  index_t  index_q;
  tag_t    tag_q;
  offset_t offset_q;

  // request is taken when ctrl is ready
  assign accept = fetch_req_i & fetch_ready_i;

  assign lookup.accept = accept;
  // arrays read in the accept cycle, so the index bypasses the register
  assign lookup.rd_index = accept ? fetch_addr_i[LINE_OFF_W +: INDEX_W] : index_q;
  assign lookup.tag      = tag_q;
  assign lookup.offset   = offset_q;

  //////////////////////////////////////////////////
  // fields of the request in flight
  //////////////////////////////////////////////////

  // held until the next accept, refill address is built from these
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      index_q  <= '0;
      tag_q    <= '0;
      offset_q <= '0;
    end else if (accept) begin
      index_q  <= fetch_addr_i[LINE_OFF_W +: INDEX_W];
      tag_q    <= fetch_addr_i[LINE_OFF_W + INDEX_W +: TAG_W];
      // low byte bits of a word are dropped
      offset_q <= fetch_addr_i[WORD_BYTE_W +: OFFSET_W];
    end
  end

endmodule

// ==== logic/icache_lookup_if.sv ====
// decoded fetch request, driven by address decode and read by ctrl and both arrays
`timescale 1ns/1ps

interface icache_lookup_if import icache_pkg::*; ();

  // fetch handshake completed this cycle
  logic    accept;
  // set to read, from the fetch address on accept
  // otherwise the index of the request in flight
  index_t  rd_index;
  // registered tag of the request in flight
  tag_t    tag;
  // registered word offset inside the line
  offset_t offset;

  modport decode (
    output accept,
    output rd_index,
    output tag,
    output offset
  );

  modport lookup (
    input accept,
    input rd_index,
    input tag,
    input offset
  );

endinterface

// ==== logic/icache_pkg.sv ====
// shared field types and controller states, imported by every cache module
package icache_pkg;

  `include "icache_cfg.svh"

  // geometry taken from the config header
  localparam int WAYS           = `ICACHE_WAYS;
  localparam int SETS           = `ICACHE_SETS;
  localparam int ADDR_W         = `ICACHE_ADDR_WIDTH;
  localparam int FETCH_W        = `ICACHE_FETCH_WIDTH;
  localparam int WAY_W          = $clog2(WAYS);
  localparam int INDEX_W        = $clog2(SETS);
  // byte offset bits inside a line and inside a word
  localparam int LINE_OFF_W     = $clog2(`ICACHE_LINE_BYTES);
  localparam int WORD_BYTE_W    = $clog2(FETCH_W / 8);
  localparam int WORDS_PER_LINE = (`ICACHE_LINE_BYTES * 8) / FETCH_W;
  localparam int OFFSET_W       = $clog2(WORDS_PER_LINE);
  // tag is what is left above index and line offset
  localparam int TAG_W          = ADDR_W - INDEX_W - LINE_OFF_W;

  localparam logic [7:0] LFSR_SEED = `ICACHE_LFSR_SEED;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [WAY_W-1:0]    way_t;
  typedef logic [WAYS-1:0]     way_vec_t;
  typedef logic [FETCH_W-1:0]  word_t;

  // word 0 sits at the lowest byte address of the line
  typedef logic [WORDS_PER_LINE-1:0][FETCH_W-1:0] line_t;

  // controller states
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

endpackage

// ==== include/icache_cfg.svh ====
// cache geometry macros, included by the package and by the testbench files
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// associativity
`define ICACHE_WAYS 2

// number of sets, one flush cycle each
`define ICACHE_SETS 16

// bytes per cache line, one refill beat
`define ICACHE_LINE_BYTES 16

// physical fetch address
`define ICACHE_ADDR_WIDTH 32

// width of one fetch word
`define ICACHE_FETCH_WIDTH 32

// reset value of the 8-bit replacement lfsr, must not be zero
`define ICACHE_LFSR_SEED 8'hA5

`endif
